//--- source/cpu_pkg.sv
// widths, depths, opcodes and the instruction word of the renaming core
// every rtl module pulls what it needs from here with a wildcard import
package cpu_pkg;

    ////////////////////
    // datapath
    localparam int DATA_W = 16;
    localparam int INST_W = 16;
    localparam int OP_W   = 2;

    ////////////////////
    // registers
    localparam int NUM_ARCH_REGS = 8;
    localparam int ARCH_REG_W    = 3;
    localparam int NUM_PREGS     = 16;
    localparam int PREG_W        = 4;

    // free list depth matches the rob, so a full rob means an empty free list
    localparam int FL_DEPTH = NUM_PREGS - NUM_ARCH_REGS;
    localparam int FL_PTR_W = 3;
    localparam int FL_CNT_W = 4;            // counts 0..FL_DEPTH

    ////////////////////
    // queues and units
    localparam int ROB_DEPTH    = 8;
    localparam int ROB_IDX_W    = 3;
    localparam int IB_DEPTH     = 4;
    localparam int IB_PTR_W     = 2;
    localparam int IB_CNT_W     = 3;        // open-entry count, 0..IB_DEPTH
    localparam int MULT_LATENCY = 3;        // issue to completion bus

    localparam logic [OP_W-1:0] OP_ADD  = 2'b00;
    localparam logic [OP_W-1:0] OP_SUB  = 2'b01;
    localparam logic [OP_W-1:0] OP_MUL  = 2'b10;
    localparam logic [OP_W-1:0] OP_ADDI = 2'b11;

    // one 16-bit word, two readings picked by opcode
    typedef union packed {
        struct packed {
            logic [OP_W-1:0]       opcode;
            logic [ARCH_REG_W-1:0] dest;
            logic [ARCH_REG_W-1:0] src1;
            logic [ARCH_REG_W-1:0] src2;
            logic [4:0]            unused;
        } r;                                // add, sub, mul
        struct packed {
            logic [OP_W-1:0]       opcode;
            logic [ARCH_REG_W-1:0] dest;
            logic [ARCH_REG_W-1:0] src1;
            logic [7:0]            imm;     // zero-extended
        } i;                                // addi
    } inst_word_t;

endpackage

//--- source/inst_buffer.sv
// small circular queue between the instruction source and dispatch
// reports how many entries are open so the source knows when to send
`timescale 1ns/1ps

module inst_buffer import cpu_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_valid,
    input  inst_word_t          in_inst,
    input  logic                take,
    output logic                head_valid,
    output inst_word_t          head_inst,
    output logic [IB_CNT_W-1:0] ib_open
);

    inst_word_t          entries [IB_DEPTH];
    logic [IB_PTR_W-1:0] head;
    logic [IB_PTR_W-1:0] tail;
    logic [IB_CNT_W-1:0] count;
    logic                push;
    logic                pop;

    assign push       = in_valid && (ib_open != '0);
    assign pop        = take && head_valid;
    assign head_valid = (count != '0);
    assign head_inst  = entries[head];
    assign ib_open    = IB_CNT_W'(IB_DEPTH) - count;

    always_ff @(posedge clock) begin
        if (push) begin
            entries[tail] <= in_inst;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;        // wraps at IB_DEPTH
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            count <= count + IB_CNT_W'(push) - IB_CNT_W'(pop);
        end
    end

    // the source must watch ib_open
    a_no_write_full: assert property (@(posedge clock) disable iff (reset)
        in_valid |-> count != IB_CNT_W'(IB_DEPTH))
        else $error("instruction offered to a full buffer");

endmodule

//--- source/rename.sv
// map table plus circular free list of physical registers
// dispatch renames through it, commit hands the old mapping back
`timescale 1ns/1ps

module rename import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic [ARCH_REG_W-1:0] dest_areg,
    input  logic [ARCH_REG_W-1:0] src1_areg,
    input  logic [ARCH_REG_W-1:0] src2_areg,
    output logic [PREG_W-1:0]     src1_preg,
    output logic [PREG_W-1:0]     src2_preg,
    output logic [PREG_W-1:0]     new_preg,
    output logic [PREG_W-1:0]     old_preg,
    input  logic                  free,
    input  logic [PREG_W-1:0]     free_preg
);

    logic [PREG_W-1:0]   map_table [NUM_ARCH_REGS];
    logic [PREG_W-1:0]   free_list [FL_DEPTH];
    logic [FL_PTR_W-1:0] fl_head;
    logic [FL_PTR_W-1:0] fl_tail;
    logic [FL_CNT_W-1:0] fl_count;

    // lookups see the map before this cycle's update, so rd == rs works
    assign src1_preg = map_table[src1_areg];
    assign src2_preg = map_table[src2_areg];
    assign old_preg  = map_table[dest_areg];
    assign new_preg  = free_list[fl_head];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_table[i] <= PREG_W'(i);                     // identity map
            end
            for (int i = 0; i < FL_DEPTH; i++) begin
                free_list[i] <= PREG_W'(NUM_ARCH_REGS + i);     // pregs 8..15
            end
            fl_head  <= '0;
            fl_tail  <= '0;
            fl_count <= FL_CNT_W'(FL_DEPTH);
        end else begin
            if (alloc) begin
                map_table[dest_areg] <= new_preg;
                fl_head              <= fl_head + 1'b1;
            end
            if (free) begin
                free_list[fl_tail] <= free_preg;                // t_old from commit
                fl_tail            <= fl_tail + 1'b1;
            end
            fl_count <= fl_count + FL_CNT_W'(free) - FL_CNT_W'(alloc);
        end
    end

    // rob_full in dispatch must cover the free list
    a_alloc_not_empty: assert property (@(posedge clock) disable iff (reset)
        alloc |-> fl_count != '0)
        else $error("rename with an empty free list");

endmodule

//--- source/phys_regfile.sv
// physical register values with a ready bit each
// alloc clears ready, the completion bus writes the value and sets it again
`timescale 1ns/1ps

module phys_regfile import cpu_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic [PREG_W-1:0] rd1_preg,
    input  logic [PREG_W-1:0] rd2_preg,
    output logic [DATA_W-1:0] rd1_data,
    output logic [DATA_W-1:0] rd2_data,
    output logic              rd1_ready,
    output logic              rd2_ready,
    input  logic              alloc,
    input  logic [PREG_W-1:0] alloc_preg,
    input  logic              cdb_valid,
    input  logic [PREG_W-1:0] cdb_preg,
    input  logic [DATA_W-1:0] cdb_data
);

    logic [DATA_W-1:0]    values [NUM_PREGS];
    logic [NUM_PREGS-1:0] ready;

    // no bypass, a result is visible the cycle after the bus
    assign rd1_data  = values[rd1_preg];
    assign rd2_data  = values[rd2_preg];
    assign rd1_ready = ready[rd1_preg];
    assign rd2_ready = ready[rd2_preg];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_PREGS; i++) begin
                values[i] <= '0;            // architectural state starts at zero
            end
            ready <= '1;
        end else begin
            if (alloc) begin
                ready[alloc_preg] <= 1'b0;
            end
            if (cdb_valid) begin
                values[cdb_preg] <= cdb_data;
                ready[cdb_preg]  <= 1'b1;
            end
        end
    end

    // each renamed register is written exactly once
    a_cdb_to_pending: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> !ready[cdb_preg])
        else $error("completion to a register that is already ready");

endmodule

//--- source/dispatch.sv
// decodes the head instruction, decides the stall and drives the issue strobe
// purely combinational so dispatch and issue share one cycle
`timescale 1ns/1ps

module dispatch import cpu_pkg::*; (
    input  logic                  head_valid,
    input  inst_word_t            head_inst,
    output logic                  take,
    input  logic                  rob_full,
    input  logic                  port_claimed,
    input  logic [PREG_W-1:0]     src1_preg,
    input  logic [PREG_W-1:0]     src2_preg,
    output logic [PREG_W-1:0]     rd1_preg,
    output logic [PREG_W-1:0]     rd2_preg,
    input  logic [DATA_W-1:0]     rd1_data,
    input  logic [DATA_W-1:0]     rd2_data,
    input  logic                  rd1_ready,
    input  logic                  rd2_ready,
    output logic                  alloc,
    output logic [ARCH_REG_W-1:0] dest_areg,
    output logic [ARCH_REG_W-1:0] src1_areg,
    output logic [ARCH_REG_W-1:0] src2_areg,
    output logic                  issue_valid,
    output logic [OP_W-1:0]       issue_op,
    output logic [DATA_W-1:0]     issue_a,
    output logic [DATA_W-1:0]     issue_b
);

    logic is_imm;
    logic is_mul;
    logic ops_ready;
    logic port_free;
    logic go;

    assign is_imm = (head_inst.r.opcode == OP_ADDI);
    assign is_mul = (head_inst.r.opcode == OP_MUL);

    // opcode, dest and src1 sit at the same bits in both views
    assign dest_areg = head_inst.r.dest;
    assign src1_areg = head_inst.r.src1;
    assign src2_areg = head_inst.r.src2;

    ////////////////////
    // operand read
    assign rd1_preg = src1_preg;
    assign rd2_preg = src2_preg;

    ////////////////////
    // stall
    assign ops_ready = rd1_ready && (is_imm || rd2_ready);
    assign port_free = is_mul || !port_claimed;          // a mul owns the bus next cycle
    assign go        = head_valid && !rob_full && ops_ready && port_free;

    assign take        = go;
    assign alloc       = go;
    assign issue_valid = go;
    assign issue_op    = head_inst.r.opcode;
    assign issue_a     = rd1_data;
    assign issue_b     = is_imm ? DATA_W'(head_inst.i.imm) : rd2_data;

endmodule

//--- source/exec_units.sv
// one-cycle add/sub unit and a pipelined three-stage multiplier
// both feed the single completion bus, dispatch keeps them from colliding
`timescale 1ns/1ps

module exec_units import cpu_pkg::*; (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 issue_valid,
    input  logic [OP_W-1:0]      issue_op,
    input  logic [DATA_W-1:0]    issue_a,
    input  logic [DATA_W-1:0]    issue_b,
    input  logic [PREG_W-1:0]    issue_preg,
    input  logic [ROB_IDX_W-1:0] issue_rob_idx,
    output logic                 port_claimed,
    output logic                 cdb_valid,
    output logic [PREG_W-1:0]    cdb_preg,
    output logic [ROB_IDX_W-1:0] cdb_rob_idx,
    output logic [DATA_W-1:0]    cdb_data
);

    logic                    is_mul;
    logic [2*DATA_W-1:0]     product;
    logic                    alu_valid;
    logic [PREG_W-1:0]       alu_preg;
    logic [ROB_IDX_W-1:0]    alu_rob;
    logic [DATA_W-1:0]       alu_data;
    logic [MULT_LATENCY-1:0] mul_valid;
    logic [PREG_W-1:0]       mul_preg [MULT_LATENCY];
    logic [ROB_IDX_W-1:0]    mul_rob  [MULT_LATENCY];
    logic [DATA_W-1:0]       mul_data [MULT_LATENCY];

    assign is_mul  = (issue_op == OP_MUL);
    assign product = issue_a * issue_b;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_valid <= 1'b0;
            mul_valid <= '0;
        end else begin
            alu_valid <= issue_valid && !is_mul;
            mul_valid <= {mul_valid[MULT_LATENCY-2:0], issue_valid && is_mul};
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid && !is_mul) begin
            alu_preg <= issue_preg;
            alu_rob  <= issue_rob_idx;
            alu_data <= (issue_op == OP_SUB) ? issue_a - issue_b : issue_a + issue_b;
        end
        mul_preg[0] <= issue_preg;
        mul_rob[0]  <= issue_rob_idx;
        mul_data[0] <= product[DATA_W-1:0];     // low half only
        for (int s = 1; s < MULT_LATENCY; s++) begin
            mul_preg[s] <= mul_preg[s-1];
            mul_rob[s]  <= mul_rob[s-1];
            mul_data[s] <= mul_data[s-1];
        end
    end

    ////////////////////
    // completion bus
    assign port_claimed = mul_valid[MULT_LATENCY-2];
    assign cdb_valid    = alu_valid || mul_valid[MULT_LATENCY-1];
    assign cdb_preg     = mul_valid[MULT_LATENCY-1] ? mul_preg[MULT_LATENCY-1] : alu_preg;
    assign cdb_rob_idx  = mul_valid[MULT_LATENCY-1] ? mul_rob[MULT_LATENCY-1]  : alu_rob;
    assign cdb_data     = mul_valid[MULT_LATENCY-1] ? mul_data[MULT_LATENCY-1] : alu_data;

    // relies on dispatch honouring port_claimed
    a_one_writer: assert property (@(posedge clock) disable iff (reset)
        !(alu_valid && mul_valid[MULT_LATENCY-1]))
        else $error("adder and multiplier completed together");

endmodule

//--- source/rob.sv
// reorder buffer, marks completions and retires the head in program order
// a retiring entry returns its old physical register to the free list
`timescale 1ns/1ps

module rob import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  alloc,
    input  logic [ARCH_REG_W-1:0] alloc_areg,
    input  logic [PREG_W-1:0]     alloc_preg,
    input  logic [PREG_W-1:0]     alloc_old_preg,
    output logic                  rob_full,
    output logic [ROB_IDX_W-1:0]  tail_idx,
    input  logic                  cdb_valid,
    input  logic [ROB_IDX_W-1:0]  cdb_rob_idx,
    input  logic [DATA_W-1:0]     cdb_data,
    output logic                  commit_valid,
    output logic [ARCH_REG_W-1:0] commit_reg,
    output logic [DATA_W-1:0]     commit_data,
    output logic [PREG_W-1:0]     free_preg
);

    logic [ARCH_REG_W-1:0] e_areg [ROB_DEPTH];
    logic [PREG_W-1:0]     e_old  [ROB_DEPTH];
    logic [DATA_W-1:0]     e_data [ROB_DEPTH];
    logic [ROB_DEPTH-1:0]  e_valid;
    logic [ROB_DEPTH-1:0]  e_done;
    logic [ROB_IDX_W-1:0]  head;
    logic [ROB_IDX_W-1:0]  tail;

    assign rob_full = e_valid[tail];            // tail caught up with head
    assign tail_idx = tail;

    // head retires the cycle after its done bit lands
    assign commit_valid = e_valid[head] && e_done[head];
    assign commit_reg   = e_areg[head];
    assign commit_data  = e_data[head];
    assign free_preg    = e_old[head];

    always_ff @(posedge clock) begin
        if (reset) begin
            e_valid <= '0;
            e_done  <= '0;
            head    <= '0;
            tail    <= '0;
        end else begin
            if (alloc) begin
                e_valid[tail] <= 1'b1;
                e_done[tail]  <= 1'b0;
                tail          <= tail + 1'b1;
            end
            if (cdb_valid) begin
                e_done[cdb_rob_idx] <= 1'b1;
            end
            if (commit_valid) begin
                e_valid[head] <= 1'b0;
                head          <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            e_areg[tail] <= alloc_areg;
            e_old[tail]  <= alloc_old_preg;
        end
        if (cdb_valid) begin
            e_data[cdb_rob_idx] <= cdb_data;
        end
    end

    a_cdb_live_entry: assert property (@(posedge clock) disable iff (reset)
        cdb_valid |-> e_valid[cdb_rob_idx] && !e_done[cdb_rob_idx])
        else $error("completion for an entry that is not waiting");

    // free list must never hand out a register that is still mapped
    a_fresh_preg: assert property (@(posedge clock) disable iff (reset)
        alloc |-> alloc_preg != alloc_old_preg)
        else $error("new physical register equals the old mapping");

endmodule

//--- source/cpu.sv
// top level of the single-issue renaming core
// instructions go in through the buffer, retired results come out on commit_*
`timescale 1ns/1ps

module cpu import cpu_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid,
    input  inst_word_t            in_inst,
    output logic [IB_CNT_W-1:0]   ib_open,
    output logic                  commit_valid,
    output logic [ARCH_REG_W-1:0] commit_reg,
    output logic [DATA_W-1:0]     commit_data
);

    ////////////////////
    // front end
    logic                  head_valid;
    inst_word_t            head_inst;
    logic                  take;
    logic                  alloc;
    logic [ARCH_REG_W-1:0] dest_areg;
    logic [ARCH_REG_W-1:0] src1_areg;
    logic [ARCH_REG_W-1:0] src2_areg;
    logic [PREG_W-1:0]     src1_preg;
    logic [PREG_W-1:0]     src2_preg;
    logic [PREG_W-1:0]     new_preg;
    logic [PREG_W-1:0]     old_preg;
    logic [PREG_W-1:0]     rd1_preg;
    logic [PREG_W-1:0]     rd2_preg;
    logic [DATA_W-1:0]     rd1_data;
    logic [DATA_W-1:0]     rd2_data;
    logic                  rd1_ready;
    logic                  rd2_ready;
    logic                  rob_full;
    logic [ROB_IDX_W-1:0]  tail_idx;

    ////////////////////
    // back end
    logic                  port_claimed;
    logic                  issue_valid;
    logic [OP_W-1:0]       issue_op;
    logic [DATA_W-1:0]     issue_a;
    logic [DATA_W-1:0]     issue_b;
    logic                  cdb_valid;
    logic [PREG_W-1:0]     cdb_preg;
    logic [ROB_IDX_W-1:0]  cdb_rob_idx;
    logic [DATA_W-1:0]     cdb_data;
    logic [PREG_W-1:0]     free_preg;

    inst_buffer i_inst_buffer (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .take(take),
        .head_valid(head_valid), .head_inst(head_inst), .ib_open(ib_open)
    );

    dispatch i_dispatch (
        .head_valid(head_valid), .head_inst(head_inst), .take(take),
        .rob_full(rob_full), .port_claimed(port_claimed),
        .src1_preg(src1_preg), .src2_preg(src2_preg),
        .rd1_preg(rd1_preg), .rd2_preg(rd2_preg),
        .rd1_data(rd1_data), .rd2_data(rd2_data),
        .rd1_ready(rd1_ready), .rd2_ready(rd2_ready),
        .alloc(alloc), .dest_areg(dest_areg),
        .src1_areg(src1_areg), .src2_areg(src2_areg),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b)
    );

    rename i_rename (
        .clock(clock), .reset(reset), .alloc(alloc),
        .dest_areg(dest_areg), .src1_areg(src1_areg), .src2_areg(src2_areg),
        .src1_preg(src1_preg), .src2_preg(src2_preg),
        .new_preg(new_preg), .old_preg(old_preg),
        .free(commit_valid), .free_preg(free_preg)
    );

    phys_regfile i_phys_regfile (
        .clock(clock), .reset(reset),
        .rd1_preg(rd1_preg), .rd2_preg(rd2_preg),
        .rd1_data(rd1_data), .rd2_data(rd2_data),
        .rd1_ready(rd1_ready), .rd2_ready(rd2_ready),
        .alloc(alloc), .alloc_preg(new_preg),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg), .cdb_data(cdb_data)
    );

    // destination tag and rob slot ride along with the operands
    exec_units i_exec_units (
        .clock(clock), .reset(reset),
        .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_a(issue_a), .issue_b(issue_b),
        .issue_preg(new_preg), .issue_rob_idx(tail_idx),
        .port_claimed(port_claimed),
        .cdb_valid(cdb_valid), .cdb_preg(cdb_preg),
        .cdb_rob_idx(cdb_rob_idx), .cdb_data(cdb_data)
    );

    rob i_rob (
        .clock(clock), .reset(reset), .alloc(alloc),
        .alloc_areg(dest_areg), .alloc_preg(new_preg), .alloc_old_preg(old_preg),
        .rob_full(rob_full), .tail_idx(tail_idx),
        .cdb_valid(cdb_valid), .cdb_rob_idx(cdb_rob_idx), .cdb_data(cdb_data),
        .commit_valid(commit_valid), .commit_reg(commit_reg),
        .commit_data(commit_data), .free_preg(free_preg)
    );

endmodule

//--- verif/cpu_tb.sv
// testbench for the renaming core, replays verif/cpu_input.txt and checks every commit
// run from the project root so the data file path resolves
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

    localparam int MAX_LINES       = 64;
    localparam int CYCLES_PER_LINE = 30;     // timeout budget per instruction

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    inst_word_t            in_inst;
    logic [IB_CNT_W-1:0]   ib_open;
    logic                  commit_valid;
    logic [ARCH_REG_W-1:0] commit_reg;
    logic [DATA_W-1:0]     commit_data;

    inst_word_t            prog_inst [MAX_LINES];
    logic [ARCH_REG_W-1:0] exp_reg   [MAX_LINES];
    logic [DATA_W-1:0]     exp_data  [MAX_LINES];
    int                    num_lines;
    int                    commit_idx;    // next expected line
    int                    cycle_count;
    int                    cycle_limit;
    logic [31:0]           rand_state;

    cpu i_cpu (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .ib_open(ib_open),
        .commit_valid(commit_valid), .commit_reg(commit_reg), .commit_data(commit_data)
    );

    initial clock = 1'b0;
    always #20 clock = ~clock;               // 40 ns period

    ////////////////////
    // helpers
    function automatic logic [31:0] lcg_step(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_and_stop();
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at %0d ns", $time);
    endtask

    task automatic check_reg(input string name, input logic [ARCH_REG_W-1:0] got,
                             input logic [ARCH_REG_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_data(input string name, input logic [DATA_W-1:0] got,
                              input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is 0x%04h, expected 0x%04h", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_count(input string name, input logic [IB_CNT_W-1:0] got,
                               input logic [IB_CNT_W-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR at %0d ns: %s is %b, expected %b", $time, name, got, exp);
            fail_and_stop();
        end
    endtask

    // columns are instruction, commit register, commit value, all hex
    task automatic load_program();
        int          fd;
        int          fields;
        bit          overflow;
        string       line;
        logic [31:0] word;
        logic [31:0] reg_no;
        logic [31:0] value;
        overflow  = 1'b0;
        num_lines = 0;
        fd = $fopen("verif/cpu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open verif/cpu_input.txt for reading");
            fail_and_stop();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%h %h %h", word, reg_no, value);
                    if (fields == 3 && num_lines < MAX_LINES) begin
                        prog_inst[num_lines] = inst_word_t'(word[INST_W-1:0]);
                        exp_reg[num_lines]   = reg_no[ARCH_REG_W-1:0];
                        exp_data[num_lines]  = value[DATA_W-1:0];
                        num_lines            = num_lines + 1;
                    end else if (fields == 3) begin
                        overflow = 1'b1;
                    end
                end
            end
            $fclose(fd);
            if (overflow || num_lines == 0) begin
                $display("input file is empty or holds more than %0d lines", MAX_LINES);
                fail_and_stop();
            end
        end
    endtask

    ////////////////////
    // driving
    task automatic idle_cycle();
        @(posedge clock);
        in_valid <= 1'b0;
    endtask

    // only offer when a slot stays open after any push already in flight
    task automatic present(input inst_word_t inst);
        @(negedge clock);
        while (int'(ib_open) - int'(in_valid) <= 0) begin
            @(posedge clock);
            in_valid <= 1'b0;
            @(negedge clock);
        end
        @(posedge clock);
        in_valid <= 1'b1;
        in_inst  <= inst;
    endtask

    initial begin
        int gap;
        reset       = 1'b1;
        in_valid    = 1'b0;
        in_inst     = '0;
        rand_state  = 32'habd6cd57;
        commit_idx  = 0;
        cycle_count = 0;
        load_program();
        cycle_limit = num_lines * CYCLES_PER_LINE;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);                    // state right after reset
        check_count("ib_open", ib_open, IB_CNT_W'(IB_DEPTH));
        check_flag("commit_valid", commit_valid, 1'b0);

        for (int i = 0; i < num_lines; i++) begin
            rand_state = lcg_step(rand_state);
            gap        = int'(rand_state[17:16]);     // 0 to 3 idle cycles
            repeat (gap) idle_cycle();
            present(prog_inst[i]);
        end
        idle_cycle();

        while (commit_idx < num_lines) @(negedge clock);
        repeat (CYCLES_PER_LINE) @(negedge clock);    // window for stray commits
        $display("RESULT: PASS");
        $finish;
    end

    ////////////////////
    // commit monitor and timeout
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (commit_idx >= num_lines) begin
                $display("a commit arrived after all %0d input lines had retired", num_lines);
                fail_and_stop();
            end else begin
                check_reg("commit_reg", commit_reg, exp_reg[commit_idx]);
                check_data("commit_data", commit_data, exp_data[commit_idx]);
                commit_idx = commit_idx + 1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("commits did not finish, %0d of %0d retired after %0d cycles",
                     commit_idx, num_lines, cycle_count);
            fail_and_stop();
        end
    end

endmodule

//--- verif/cpu_input.txt
# columns: instruction word, expected commit register, expected commit value (all hex)
# values follow sequential execution from all-zero registers
C805 1 0005
D007 2 0007
1940 3 000C
6320 4 0007
6940 5 FFFE
# dependent chain on r6
F601 6 0001
36C0 6 0002
36C0 6 0004
F6FF 6 0103
# multiply then independent adds
BB40 7 0054
0A40 1 000E
D003 2 0003
2720 4 0062
ADA0 5 0004
9FE0 3 1B90
# long run of writes to r2
97E0 2 1B90
D011 2 0011
D222 2 0033
1280 2 0095
5220 2 0087
9240 2 4731
D180 2 008E
1660 2 1C93
5040 2 E36D
D201 2 E36E
92E0 2 A018
D2FF 2 A117
02A0 0 A11B
48C0 1 A018

//--- list.f
source/cpu_pkg.sv
source/inst_buffer.sv
source/rename.sv
source/phys_regfile.sv
source/dispatch.sv
source/exec_units.sv
source/rob.sv
source/cpu.sv
verif/cpu_tb.sv

//--- Makefile
# Verilator flow for the renaming core, run from the project root
TOP       ?= cpu_tb
FILELIST  ?= list.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the testbench printed the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
